//--- vlog.f
+incdir+verif
hdl/decodePkg.sv
hdl/instrQueueIf.sv
hdl/wbInstrPort.sv
hdl/instrFifo.sv
hdl/ctrlDecoder.sv
hdl/decodeTop.sv
verif/tbDecodeTop.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbDecodeTop
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/VtbDecodeTop > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$logFile"; then
	exit 1
fi
exit 0

//--- verif/tbRefModel.svh
// needs decodePkg imported by the including module, and any encoding outside the table gives ctrlIdle
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic aluOp_t aluForFunct(input logic [5:0] fn);
	case (fn)
		fnAdd, fnAddu: return aluAdd; // addu shares the signed adder
		fnSub: return aluSub;
		fnSubu: return aluSubU;
		fnAnd: return aluAnd;
		fnOr: return aluOr;
		fnXor: return aluXor;
		fnNor: return aluNor;
		fnSlt: return aluSlt;
		default: return aluSltu;
	endcase
endfunction

function automatic memOp_t memOpFor(input logic [5:0] op);
	case (op)
		opLb: return memByte;
		opLbu: return memByteU;
		opLh: return memHalf;
		opLhu: return memHalfU;
		opLw: return memWord;
		opSb: return memStoreByte;
		opSh: return memStoreHalf;
		default: return memNone; // sw
	endcase
endfunction

function automatic ctrlWord_t refDecode(input logic [31:0] w);
	ctrlWord_t e;
	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rt;
	logic load;
	logic subWord;
	op = w[31:26];
	fn = w[5:0];
	rt = w[20:16];
	load = !op[3]; // 100xxx loads, 101xxx stores
	subWord = op[1:0] != 2'b11;
	e = ctrlIdle;
	case (op)
		opSpecial:
			case (fn)
				fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu:
				begin
					e.regWrite = 1'b1;
					e.exResultSrc = resAlu;
					e.rtRead = 1'b1;
					e.aluOp = aluForFunct(fn);
					e.overflowTrap = fn == fnAdd || fn == fnSub || fn == fnSlt;
				end
				fnSll, fnSllv, fnSra, fnSrav, fnSrl, fnSrlv:
				begin
					e.regWrite = 1'b1;
					e.exResultSrc = resShift;
					e.rtRead = 1'b1;
					e.shiftAmountSel = fn[2] ? amtReg : amtShamt; // variable forms have bit 2
					if (fn[1:0] == 2'b00)
						e.shiftOp = shLeft;
					else if (fn[1:0] == 2'b11)
						e.shiftOp = shRightArith;
					else if (fn[2] ? w[6] : w[21])
					begin
						e.shiftOp = shRotateRight;
						e.extendImm = extZero;
					end
					else
						e.shiftOp = shRightLogical;
				end
				default: e = ctrlIdle;
			endcase
		opSpecial2:
			if (fn == fnClo || fn == fnClz)
			begin
				e.regWrite = 1'b1;
				e.exResultSrc = resAlu;
				e.aluOp = (fn == fnClo) ? aluClo : aluClz;
			end
		opSpecial3:
		begin
			e.regWrite = 1'b1;
			e.exResultSrc = resAlu;
			e.aluOp = aluSeb;
			e.rtRead = 1'b1;
		end
		opRegimm:
			if (rt == rtBgez || rt == rtBgezal || rt == rtBltzal)
			begin
				e.branch = 1'b1;
				e.condition = (rt == rtBltzal) ? condLtZero : condGeZero;
				e.aluSrcB = srcBConst;
				e.aluOp = aluSubU;
				e.extendImm = extBranch;
				e.overflowTrap = 1'b1;
				e.regDst = dstRa;
				e.regWrite = rt[4]; // link forms
			end
		opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opLui:
		begin
			e.regWrite = 1'b1;
			e.exResultSrc = resAlu;
			e.aluSrcB = srcBImm;
			e.regDst = dstRt;
			e.overflowTrap = op == opAddi;
			e.extendImm = (op == opAddi || op == opSlti) ? extSign : extZero;
			case (op)
				opAddi: e.aluOp = aluAdd;
				opAndi: e.aluOp = aluAnd;
				opOri: e.aluOp = aluOr;
				opXori: e.aluOp = aluXor;
				opSlti: e.aluOp = aluSlt;
				default: e.aluOp = aluAddU;
			endcase
			if (op == opLui)
			begin
				e.extendImm = extUpper;
				e.aluSrcA = 1'b1;
			end
		end
		opLb, opLbu, opLh, opLhu, opLw, opSb, opSh, opSw:
		begin
			e.regWrite = load;
			e.memRead = load;
			e.memWrite = !load;
			e.memOp = memOpFor(op);
			e.exResultSrc = resAlu;
			e.aluSrcB = srcBImm;
			e.regDst = dstRt;
			e.shiftOp = (load && subWord) ? shRightArith : shLeft;
			e.rtRead = !load && subWord;
		end
		opJ: e.jump = 1'b1;
		opJal, opBeq, opBne, opBlez:
		begin
			e.branch = 1'b1;
			e.extendImm = extBranch;
			e.condition = (op == opBne) ? condNotEqual : (op == opBlez) ? condLeZero : condAlways;
			e.aluOp = (op == opBne || op == opBlez) ? aluSubU : aluAddU;
			e.overflowTrap = op == opBne || op == opBlez;
			if (op == opJal || op == opBlez)
				e.aluSrcB = srcBConst;
			else if (op == opBeq)
				e.aluSrcB = srcBImm;
			if (op == opJal)
			begin
				e.regWrite = 1'b1;
				e.regDst = dstRa;
			end
			if (op == opBeq)
				e.exResultSrc = resAlu;
			e.rtRead = op == opBne;
		end
		default: e = ctrlIdle;
	endcase
	return e;
endfunction

`endif

//--- verif/tbDecodeTop.sv
// drives a single Wishbone master and checks every output transfer in order, fifoDepth is 4
`timescale 1ns/1ps

module tbDecodeTop;
	import decodePkg::*;
	`include "tbRefModel.svh"

	localparam int fifoDepth = 4;
	localparam int timeoutCycles = 4000; // about ten times the test length

	logic clk;
	logic rst;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [31:0] wbDatI;
	logic [31:0] wbDatO;
	logic wbAck;
	logic ctrlValid;
	logic ctrlReady = 1'b0;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic [3:0] memOp;
	logic branch;
	logic [2:0] condition;
	logic jump;
	logic [3:0] aluOp;
	logic aluSrcA;
	logic [1:0] aluSrcB;
	logic [1:0] exResultSrc;
	logic [1:0] regDst;
	logic [1:0] shiftAmountSel;
	logic [1:0] shiftOp;
	logic [1:0] extendImm;
	logic rtRead;
	logic overflowTrap;

	ctrlWord_t actual;
	ctrlWord_t expected;
	logic [31:0] headWord;
	logic [31:0] readData;
	logic [31:0] expQ [$]; // words written and not yet seen at the output
	integer seed;
	string testName;
	int errorCount = 0;
	int errorsAtStart = 0;
	int checkCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	logic randomReady = 1'b0;
	logic holdReady = 1'b1;

	logic [5:0] regFns [16] = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
		fnSlt, fnSltu, fnSll, fnSllv, fnSra, fnSrav, fnSrl, fnSrlv};
	logic [5:0] immMemOps [15] = '{opAddi, opAddiu, opAndi, opOri, opXori, opSlti, opLui,
		opLb, opLbu, opLh, opLhu, opLw, opSb, opSh, opSw};
	logic [5:0] branchOps [5] = '{opBeq, opBne, opBlez, opJ, opJal};
	logic [5:0] unknownOps [5] = '{6'b000111, 6'b010000, 6'b100010, 6'b101110, 6'b110001};
	logic [5:0] unknownFns [4] = '{6'b001000, 6'b011000, 6'b001100, 6'b000001};

	decodeTop #(.fifoDepth(fifoDepth)) i_dut (.*);

	assign actual = {regWrite, memRead, memWrite, memOp, branch, condition, jump, aluOp,
		aluSrcA, aluSrcB, exResultSrc, regDst, shiftAmountSel, shiftOp, extendImm, rtRead,
		overflowTrap};

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(negedge clk)
	begin
		if (randomReady)
			ctrlReady <= 1'($random(seed));
		else
			ctrlReady <= holdReady;
	end

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout in test %s with %0d words still expected", testName, expQ.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	always @(posedge clk)
	begin
		if (!rst && ctrlValid && ctrlReady)
		begin
			if (expQ.size() == 0)
			begin
				$display("ERROR %s: control word transferred with no word written", testName);
				errorCount++;
			end
			else
			begin
				headWord = expQ.pop_front();
				expected = refDecode(headWord);
				checkCount++;
				if (actual !== expected)
				begin
					$display("ERROR %s: word %h expected %h actual %h", testName, headWord,
						expected, actual);
					errorCount++;
				end
			end
		end
	end

	task automatic busWrite(input logic [31:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbDatI = data;
		do
			@(negedge clk);
		while (!wbAck);
		@(negedge clk); // cycle stays open through the acking edge
		expQ.push_back(data);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic busRead(output logic [31:0] data);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		do
			@(negedge clk);
		while (!wbAck);
		data = wbDatO;
		@(negedge clk);
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic startTest(input string name);
		testName = name;
		errorsAtStart = errorCount;
	endtask

	task automatic endTest;
		while (expQ.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk); // catches a stray extra transfer
		testsRun++;
		if (errorCount != errorsAtStart)
			testsFailed++;
		$display("test %s finished with %0d errors", testName, errorCount - errorsAtStart);
	endtask

	task automatic checkIdle(input string when);
		if (wbAck !== 1'b0)
		begin
			$display("ERROR %s: wbAck %s expected 0 actual %b", testName, when, wbAck);
			errorCount++;
		end
		if (ctrlValid !== 1'b0)
		begin
			$display("ERROR %s: ctrlValid %s expected 0 actual %b", testName, when, ctrlValid);
			errorCount++;
		end
	endtask

	task automatic testRegShift;
		logic [31:0] r;
		logic [31:0] w;
		startTest("register and shift");
		foreach (regFns[i])
			for (int k = 0; k < 4; k++)
			begin
				r = $random(seed);
				w = {opSpecial, r[25:6], regFns[i]};
				if (regFns[i] == fnSrl)
					w[21] = k[0]; // srl or rotr
				if (regFns[i] == fnSrlv)
					w[6] = k[0];
				busWrite(w);
			end
		for (int k = 0; k < 4; k++)
		begin
			r = $random(seed);
			busWrite({opSpecial2, r[25:6], fnClo});
			busWrite({opSpecial2, r[25:6], fnClz});
			busWrite({opSpecial3, r[25:0]}); // seb
		end
		endTest();
	endtask

	task automatic testImmMem;
		logic [31:0] r;
		startTest("immediate and memory");
		foreach (immMemOps[i])
			repeat (2)
			begin
				r = $random(seed);
				busWrite({immMemOps[i], r[25:0]});
			end
		endTest();
	endtask

	task automatic testBranch;
		logic [31:0] r;
		startTest("branch and jump");
		foreach (branchOps[i])
			repeat (2)
			begin
				r = $random(seed);
				busWrite({branchOps[i], r[25:0]});
			end
		repeat (2)
		begin
			r = $random(seed);
			busWrite({opRegimm, r[25:21], rtBgez, r[15:0]});
			busWrite({opRegimm, r[25:21], rtBgezal, r[15:0]});
			busWrite({opRegimm, r[25:21], rtBltzal, r[15:0]});
		end
		endTest();
	endtask

	task automatic testUnknown;
		logic [31:0] r;
		startTest("unknown encodings");
		r = $random(seed);
		foreach (unknownOps[i])
			busWrite({unknownOps[i], r[25:0]});
		foreach (unknownFns[i])
			busWrite({opSpecial, r[25:6], unknownFns[i]});
		busWrite({opSpecial2, r[25:6], 6'b000010}); // mul
		busWrite({opRegimm, r[25:21], 5'b00000, r[15:0]});
		busWrite({opRegimm, r[25:21], 5'b00010, r[15:0]});
		endTest();
	endtask

	task automatic testBackPressure;
		logic [31:0] r;
		startTest("back-pressure");
		holdReady = 1'b0;
		repeat (2) @(negedge clk);
		for (int i = 0; i <= fifoDepth; i++)
		begin
			r = $random(seed);
			busWrite({immMemOps[i], r[25:0]}); // distinct control words keep order visible
		end
		busRead(readData);
		if (readData != fifoDepth)
		begin
			$display("ERROR %s: level expected %0d actual %0d", testName, fifoDepth, readData);
			errorCount++;
		end
		r = $random(seed);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbDatI = {immMemOps[fifoDepth + 1], r[25:0]};
		repeat (8)
		begin
			@(negedge clk);
			if (wbAck)
			begin
				$display("ERROR %s: write acked while the queue was full", testName);
				errorCount++;
			end
		end
		holdReady = 1'b1;
		do
			@(negedge clk);
		while (!wbAck);
		@(negedge clk);
		expQ.push_back(wbDatI);
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		endTest();
	endtask

	task automatic testRandomReady;
		logic [31:0] r;
		startTest("random ready");
		randomReady = 1'b1;
		repeat (24)
		begin
			r = $random(seed);
			busWrite({immMemOps[r[31:24] % 15], r[25:0]});
		end
		endTest();
		randomReady = 1'b0;
	endtask

	initial
	begin
		seed = 32'h78b4;
		rst = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbDatI = '0;
		startTest("reset");
		repeat (5)
		begin
			@(negedge clk);
			checkIdle("during reset");
		end
		rst = 1'b0;
		@(negedge clk);
		checkIdle("after reset");
		busRead(readData);
		if (readData != 0)
		begin
			$display("ERROR %s: level expected 0 actual %0d", testName, readData);
			errorCount++;
		end
		endTest();
		testRegShift();
		testImmMem();
		testBranch();
		testUnknown();
		testBackPressure();
		testRandomReady();
		$display("tests %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- hdl/decodeTop.sv
// field ports mirror ctrlWord_t and wbDatO carries the level only on an acked read
`timescale 1ns/1ps

module decodeTop
#(
	parameter int fifoDepth = 4
)
(
	input logic clk,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [decodePkg::instrWidth-1:0] wbDatI,
	output logic [decodePkg::instrWidth-1:0] wbDatO,
	output logic wbAck,
	output logic ctrlValid,
	input logic ctrlReady,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic [3:0] memOp,
	output logic branch,
	output logic [2:0] condition,
	output logic jump,
	output logic [3:0] aluOp,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [1:0] exResultSrc,
	output logic [1:0] regDst,
	output logic [1:0] shiftAmountSel,
	output logic [1:0] shiftOp,
	output logic [1:0] extendImm,
	output logic rtRead,
	output logic overflowTrap
);
	import decodePkg::*;

	ctrlWord_t ctrl;

	instrQueueIf #(.fifoDepth(fifoDepth)) instrQ ();

	wbInstrPort i_wbPort (.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck), .q(instrQ));
	instrFifo #(.fifoDepth(fifoDepth)) i_fifo (.clk(clk), .rst(rst), .q(instrQ));
	ctrlDecoder i_decoder (.clk(clk), .rst(rst), .ctrlReady(ctrlReady), .q(instrQ),
		.ctrlValid(ctrlValid), .ctrl(ctrl));

	assign regWrite = ctrl.regWrite;
	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;
	assign memOp = ctrl.memOp;
	assign branch = ctrl.branch;
	assign condition = ctrl.condition;
	assign jump = ctrl.jump;
	assign aluOp = ctrl.aluOp;
	assign aluSrcA = ctrl.aluSrcA;
	assign aluSrcB = ctrl.aluSrcB;
	assign exResultSrc = ctrl.exResultSrc;
	assign regDst = ctrl.regDst;
	assign shiftAmountSel = ctrl.shiftAmountSel;
	assign shiftOp = ctrl.shiftOp;
	assign extendImm = ctrl.extendImm;
	assign rtRead = ctrl.rtRead;
	assign overflowTrap = ctrl.overflowTrap;

endmodule

//--- hdl/ctrlDecoder.sv
// unknown encodings emit ctrlIdle and rotate selection comes from instruction bits 21 and 6
`timescale 1ns/1ps

module ctrlDecoder
(
	input logic clk,
	input logic rst,
	input logic ctrlReady,
	instrQueueIf.consumer q,
	output logic ctrlValid,
	output decodePkg::ctrlWord_t ctrl
);
	import decodePkg::*;

	logic [5:0] opField;
	logic [5:0] fnField;
	logic [4:0] rtField;
	ctrlWord_t dec;

	function automatic ctrlWord_t regOp(aluOp_t alu, logic trap, logic rtRd);
		ctrlWord_t w;
		w = ctrlIdle;
		w.regWrite = 1'b1;
		w.exResultSrc = resAlu;
		w.aluOp = alu;
		w.rtRead = rtRd;
		w.overflowTrap = trap;
		return w;
	endfunction

	function automatic ctrlWord_t shiftWord(shiftOp_t dir, shiftAmountSel_t amt);
		ctrlWord_t w;
		w = ctrlIdle;
		w.regWrite = 1'b1;
		w.exResultSrc = resShift;
		w.shiftOp = dir;
		w.shiftAmountSel = amt;
		w.extendImm = (dir == shRotateRight) ? extZero : extSign; // rotates flag extendImm too
		w.rtRead = 1'b1;
		return w;
	endfunction

	function automatic ctrlWord_t immOp(aluOp_t alu, extendImm_t ext, logic trap);
		ctrlWord_t w;
		w = regOp(alu, trap, 1'b0);
		w.aluSrcB = srcBImm;
		w.regDst = dstRt;
		w.extendImm = ext;
		return w;
	endfunction

	function automatic ctrlWord_t memAccess(memOp_t m, logic load, logic subWord);
		ctrlWord_t w;
		w = ctrlIdle;
		w.regWrite = load;
		w.memRead = load;
		w.memWrite = !load;
		w.memOp = m;
		w.exResultSrc = resAlu;
		w.aluSrcB = srcBImm;
		w.regDst = dstRt;
		w.shiftOp = (load && subWord) ? shRightArith : shLeft; // sub-word loads align
		w.rtRead = !load && subWord;
		return w;
	endfunction

	function automatic ctrlWord_t branchOp(branchCond_t c, aluSrcB_t b, aluOp_t alu, logic trap);
		ctrlWord_t w;
		w = ctrlIdle;
		w.branch = 1'b1;
		w.condition = c;
		w.aluSrcB = b;
		w.aluOp = alu;
		w.extendImm = extBranch;
		w.overflowTrap = trap;
		return w;
	endfunction

	assign opField = q.popData[31:26];
	assign fnField = q.popData[5:0];
	assign rtField = q.popData[20:16];

	always_comb
	begin
		dec = ctrlIdle;
		case (opField)
			opSpecial:
				case (fnField)
					fnAdd: dec = regOp(aluAdd, 1'b1, 1'b1);
					fnAddu: dec = regOp(aluAdd, 1'b0, 1'b1); // same adder, no trap
					fnSub: dec = regOp(aluSub, 1'b1, 1'b1);
					fnSubu: dec = regOp(aluSubU, 1'b0, 1'b1);
					fnAnd: dec = regOp(aluAnd, 1'b0, 1'b1);
					fnOr: dec = regOp(aluOr, 1'b0, 1'b1);
					fnXor: dec = regOp(aluXor, 1'b0, 1'b1);
					fnNor: dec = regOp(aluNor, 1'b0, 1'b1);
					fnSlt: dec = regOp(aluSlt, 1'b1, 1'b1);
					fnSltu: dec = regOp(aluSltu, 1'b0, 1'b1);
					fnSll: dec = shiftWord(shLeft, amtShamt);
					fnSllv: dec = shiftWord(shLeft, amtReg);
					fnSra: dec = shiftWord(shRightArith, amtShamt);
					fnSrav: dec = shiftWord(shRightArith, amtReg);
					fnSrl: dec = shiftWord(q.popData[21] ? shRotateRight : shRightLogical, amtShamt);
					fnSrlv: dec = shiftWord(q.popData[6] ? shRotateRight : shRightLogical, amtReg);
					default: dec = ctrlIdle;
				endcase
			opSpecial2:
				case (fnField)
					fnClo: dec = regOp(aluClo, 1'b0, 1'b0);
					fnClz: dec = regOp(aluClz, 1'b0, 1'b0);
					default: dec = ctrlIdle;
				endcase
			opSpecial3: dec = regOp(aluSeb, 1'b0, 1'b1);
			opRegimm:
				if (rtField inside {rtBgez, rtBgezal, rtBltzal})
				begin
					dec = branchOp(rtField == rtBltzal ? condLtZero : condGeZero, srcBConst,
						aluSubU, 1'b1);
					dec.regDst = dstRa;
					dec.regWrite = rtField != rtBgez; // link variants
				end
			opAddi: dec = immOp(aluAdd, extSign, 1'b1);
			opAddiu: dec = immOp(aluAddU, extZero, 1'b0);
			opAndi: dec = immOp(aluAnd, extZero, 1'b0);
			opOri: dec = immOp(aluOr, extZero, 1'b0);
			opXori: dec = immOp(aluXor, extZero, 1'b0);
			opSlti: dec = immOp(aluSlt, extSign, 1'b0);
			opLui:
			begin
				dec = immOp(aluAddU, extUpper, 1'b0);
				dec.aluSrcA = 1'b1;
			end
			opJ: dec.jump = 1'b1;
			opJal:
			begin
				dec = branchOp(condAlways, srcBConst, aluAddU, 1'b0);
				dec.regWrite = 1'b1;
				dec.regDst = dstRa;
			end
			opBeq:
			begin
				dec = branchOp(condAlways, srcBImm, aluAddU, 1'b0);
				dec.exResultSrc = resAlu;
			end
			opBne:
			begin
				dec = branchOp(condNotEqual, srcBReg, aluSubU, 1'b1);
				dec.rtRead = 1'b1;
			end
			opBlez: dec = branchOp(condLeZero, srcBConst, aluSubU, 1'b1);
			opLb: dec = memAccess(memByte, 1'b1, 1'b1);
			opLbu: dec = memAccess(memByteU, 1'b1, 1'b1);
			opLh: dec = memAccess(memHalf, 1'b1, 1'b1);
			opLhu: dec = memAccess(memHalfU, 1'b1, 1'b1);
			opLw: dec = memAccess(memWord, 1'b1, 1'b0);
			opSb: dec = memAccess(memStoreByte, 1'b0, 1'b1);
			opSh: dec = memAccess(memStoreHalf, 1'b0, 1'b1);
			opSw: dec = memAccess(memNone, 1'b0, 1'b0); // full word store needs no memOp
			default: dec = ctrlIdle;
		endcase
	end

	assign q.popReady = !ctrlValid || ctrlReady; // output register empty or draining

	always_ff @(posedge clk)
	begin
		if (rst)
			ctrlValid <= 1'b0;
		else if (q.popReady)
			ctrlValid <= q.popValid;
	end

	always_ff @(posedge clk)
	begin
		if (q.popReady && q.popValid)
			ctrl <= dec;
	end

	assert property (@(posedge clk) disable iff (rst)
		ctrlValid && !ctrlReady |=> ctrlValid && $stable(ctrl))
		else $error("control word changed while stalled");

endmodule

//--- hdl/instrFifo.sv
// fifoDepth must be a power of two no smaller than 2
`timescale 1ns/1ps

module instrFifo
#(
	parameter int fifoDepth = 4
)
(
	input logic clk,
	input logic rst,
	instrQueueIf.fifo q
);
	import decodePkg::*;

	localparam int ptrWidth = $clog2(fifoDepth);
	localparam int levelWidth = $clog2(fifoDepth + 1);

	logic [instrWidth-1:0] mem [fifoDepth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic push;
	logic pop;

	assign push = q.pushValid && !q.full;
	assign pop = q.popValid && q.popReady;
	assign q.full = q.level == levelWidth'(fifoDepth);
	assign q.popValid = q.level != '0;
	assign q.popData = mem[rdPtr]; // head word, one cycle after its push

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			q.level <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1; // wraps at the power-of-two depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: q.level <= q.level + 1'b1;
				2'b01: q.level <= q.level - 1'b1;
				default: q.level <= q.level;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= q.pushData;
	end

	// producer has already acked the word, so a full queue would drop it
	assert property (@(posedge clk) disable iff (rst) q.pushValid |-> !q.full)
		else $error("push offered while queue full");
	assert property (@(posedge clk) disable iff (rst)
		pop |-> rdPtr != wrPtr || q.full)
		else $error("pop from an empty queue");

endmodule

//--- hdl/wbInstrPort.sv
// address lines are not decoded and there is no err or rty, reads return the queue level
`timescale 1ns/1ps

module wbInstrPort
(
	input logic clk,
	input logic rst,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [decodePkg::instrWidth-1:0] wbDatI,
	output logic [decodePkg::instrWidth-1:0] wbDatO,
	output logic wbAck,
	instrQueueIf.producer q
);
	import decodePkg::*;

	logic writeReq;
	logic readReq;

	assign writeReq = wbCyc && wbStb && wbWe && !q.full && !wbAck; // stall while full
	assign readReq = wbCyc && wbStb && !wbWe && !wbAck;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wbAck <= 1'b0;
			q.pushValid <= 1'b0;
		end
		else
		begin
			wbAck <= writeReq || readReq; // ack high forces a gap cycle
			q.pushValid <= writeReq;
		end
	end

	always_ff @(posedge clk)
	begin
		if (writeReq)
			q.pushData <= wbDatI;
		if (readReq)
			wbDatO <= instrWidth'(q.level);
	end

	assert property (@(posedge clk) disable iff (rst) wbAck |-> wbCyc && wbStb)
		else $error("wbAck without an open cycle");

endmodule

//--- hdl/instrQueueIf.sv
// level width follows fifoDepth and every side must be built with the same depth
`timescale 1ns/1ps

interface instrQueueIf
#(
	parameter int fifoDepth = 4
);
	import decodePkg::*;

	logic pushValid;
	logic [instrWidth-1:0] pushData;
	logic full;
	logic popValid;
	logic [instrWidth-1:0] popData;
	logic popReady;
	logic [$clog2(fifoDepth + 1)-1:0] level; // words held in the queue

	modport producer (output pushValid, output pushData, input full, input level);
	modport fifo (input pushValid, input pushData, input popReady,
		output full, output popValid, output popData, output level);
	modport consumer (input popValid, input popData, output popReady);

endinterface

//--- hdl/decodePkg.sv
// encodings match the core's control table and the unaligned lwl/lwr/swl/swr group is not decoded
package decodePkg;

	localparam int instrWidth = 32;

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm = 6'b000001;
	localparam logic [5:0] opSpecial2 = 6'b011100;
	localparam logic [5:0] opSpecial3 = 6'b011111; // seb only
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opLui = 6'b001111;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opJal = 6'b000011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opBlez = 6'b000110;
	localparam logic [5:0] opLb = 6'b100000;
	localparam logic [5:0] opLbu = 6'b100100;
	localparam logic [5:0] opLh = 6'b100001;
	localparam logic [5:0] opLhu = 6'b100101;
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSb = 6'b101000;
	localparam logic [5:0] opSh = 6'b101001;
	localparam logic [5:0] opSw = 6'b101011;

	localparam logic [5:0] fnAdd = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnSrl = 6'b000010; // rotr when bit 21 set
	localparam logic [5:0] fnSrlv = 6'b000110; // rotrv when bit 6 set
	localparam logic [5:0] fnClo = 6'b100001; // special2 group
	localparam logic [5:0] fnClz = 6'b100000;

	localparam logic [4:0] rtBgez = 5'b00001;
	localparam logic [4:0] rtBgezal = 5'b10001;
	localparam logic [4:0] rtBltzal = 5'b10000;

	typedef enum logic [3:0]
	{
		aluAddU = 4'd0, aluSubU = 4'd1, aluClz = 4'd2, aluClo = 4'd3, aluAnd = 4'd4,
		aluSlt = 4'd5, aluOr = 4'd6, aluSltu = 4'd7, aluNor = 4'd8, aluXor = 4'd9,
		aluSeb = 4'd10, aluAdd = 4'd14, aluSub = 4'd15
	} aluOp_t;

	typedef enum logic [3:0]
	{
		memNone = 4'd0, memWord = 4'd2, memByte = 4'd6, memByteU = 4'd7,
		memHalf = 4'd8, memHalfU = 4'd9, memStoreByte = 4'd10, memStoreHalf = 4'd11
	} memOp_t;

	typedef enum logic [2:0]
	{
		condNone = 3'd0, condNotEqual = 3'd2, condGeZero = 3'd4,
		condLtZero = 3'd5, condLeZero = 3'd6, condAlways = 3'd7
	} branchCond_t;

	typedef enum logic [1:0] {shLeft, shRightLogical, shRightArith, shRotateRight} shiftOp_t;
	typedef enum logic [1:0] {extSign, extZero, extBranch, extUpper} extendImm_t;
	typedef enum logic [1:0] {dstRd = 2'd0, dstRt = 2'd1, dstRa = 2'd2} regDst_t;
	typedef enum logic [1:0] {srcBReg = 2'd0, srcBImm = 2'd1, srcBConst = 2'd2} aluSrcB_t;
	typedef enum logic [1:0] {resLink = 2'd0, resAlu = 2'd1, resShift = 2'd2} exResultSrc_t;
	typedef enum logic [1:0] {amtShamt = 2'd0, amtReg = 2'd2} shiftAmountSel_t;

	typedef struct packed
	{
		logic regWrite;
		logic memRead;
		logic memWrite;
		memOp_t memOp;
		logic branch;
		branchCond_t condition;
		logic jump;
		aluOp_t aluOp;
		logic aluSrcA; // 1 selects the upper-immediate path
		aluSrcB_t aluSrcB;
		exResultSrc_t exResultSrc;
		regDst_t regDst;
		shiftAmountSel_t shiftAmountSel;
		shiftOp_t shiftOp;
		extendImm_t extendImm;
		logic rtRead;
		logic overflowTrap;
	} ctrlWord_t;

	localparam ctrlWord_t ctrlIdle = '0; // every field at its inactive code

endpackage
